// File: processer.f
+incdir+rtl
rtl/usiPkg.sv
rtl/usiBusMaster.sv
rtl/usiInterconnect.sv
rtl/gpioBlock.sv
rtl/pwmBlock.sv
rtl/processer.sv
verif/clockGen.sv
verif/processerTb.sv

// File: verif/processerTb.sv
// Table rows run one command at a time; PWM check assumes duty <= period+1 and enable left set
`default_nettype none

`include "usiBus_settings.svh"

module processerTb;
	timeunit 1ns;
	timeprecision 1ps;

	import usiPkg::*;

	//----------------------------------------------------------
	// Test geometry
	//----------------------------------------------------------
	localparam int CLK_PERIOD = 40;
	localparam int NUM_ROWS = 23;
	// Upper bound on cycles spent per table row
	localparam int ROW_BOUND = 40;
	localparam int SETTLE_CYCLES = 4;
	localparam int RSP_LATENCY = 3;
	localparam int RSP_LIMIT = 8;
	localparam int MAX_STALL = 3;
	// Backlight setup used by the table
	localparam int PWM_PERIOD = 9;
	localparam int PWM_DUTY = 3;
	localparam int DUTY_PERIODS = 4;
	localparam int OFF_PERIODS = 2;
	localparam int WATCHDOG_CYCLES = 20 + (NUM_ROWS + 1) * ROW_BOUND
		+ (DUTY_PERIODS + OFF_PERIODS) * (PWM_PERIOD + 1);
	localparam logic WR = 1'b1;
	localparam logic RD = 1'b0;

	// One table row
	typedef struct packed
	{
		logic write;
		busAdrs_t adrs;
		busData_t wData;
		busData_t rData;
		logic err;
		logic [`GPIO_IN_WIDTH-1:0] pins;
	} step_t;

	logic sysClk;
	logic reset;
	logic cmdValid;
	logic cmdReady;
	logic cmdWrite;
	busAdrs_t cmdAdrs;
	busData_t cmdData;
	logic rspValid;
	logic rspReady;
	busData_t rspData;
	logic rspError;
	logic [`LED_WIDTH-1:0] leds;
	logic [`GPIO_IN_WIDTH-1:0] gpioIn;
	logic backlight;

	step_t steps [NUM_ROWS];
	integer seed;
	// Reference model of the slave registers
	logic [`LED_WIDTH-1:0] ledModel;
	pwmCount_t periodModel;
	pwmCount_t dutyModel;
	logic enableModel;

	clockGen u_clockGen (.sysClk, .reset);

	processer u_processer (.sysClk, .reset, .cmdValid, .cmdReady, .cmdWrite, .cmdAdrs,
		.cmdData, .rspValid, .rspReady, .rspData, .rspError, .leds, .gpioIn, .backlight);

	//----------------------------------------------------------
	// Failure reporting and checks
	//----------------------------------------------------------
	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic checkValue(input string name, input busData_t got, input busData_t expected);
		assert (got === expected)
		else failRun($sformatf("FAILED at %0d ns: %s is %h, expected %h", $time, name, got,
			expected));
	endtask

	//----------------------------------------------------------
	// Stimulus table
	//----------------------------------------------------------
	task automatic loadTable();
		// op, address, write data, read data, error, input pins
		steps[0] = '{WR, 16'h0100, 32'hFFFF_FFFE, 32'h0, 1'b0, 4'h0};
		steps[1] = '{RD, 16'h0100, 32'h0, 32'h0000_0002, 1'b0, 4'h0};
		steps[2] = '{WR, 16'h0100, 32'h0000_0001, 32'h0, 1'b0, 4'h3};
		steps[3] = '{RD, 16'h0100, 32'h0, 32'h0000_0001, 1'b0, 4'h3};
		// Input pins through the synchronizer
		steps[4] = '{RD, 16'h0101, 32'h0, 32'h0000_000A, 1'b0, 4'hA};
		steps[5] = '{RD, 16'h0101, 32'h0, 32'h0000_0005, 1'b0, 4'h5};
		// Unused GPIO offsets
		steps[6] = '{RD, 16'h0105, 32'h0, 32'h0, 1'b0, 4'hF};
		steps[7] = '{WR, 16'h0107, 32'hFFFF_FFFF, 32'h0, 1'b0, 4'hF};
		// Backlight setup, upper bits dropped on read
		steps[8] = '{WR, 16'h0200, 32'hABCD_0000 | PWM_PERIOD, 32'h0, 1'b0, 4'h0};
		steps[9] = '{WR, 16'h0201, busData_t'(PWM_DUTY), 32'h0, 1'b0, 4'h0};
		steps[10] = '{RD, 16'h0200, 32'h0, busData_t'(PWM_PERIOD), 1'b0, 4'h0};
		steps[11] = '{RD, 16'h0201, 32'h0, busData_t'(PWM_DUTY), 1'b0, 4'h0};
		steps[12] = '{WR, 16'h0203, 32'h1234_5678, 32'h0, 1'b0, 4'h0};
		steps[13] = '{RD, 16'h0203, 32'h0, 32'h0, 1'b0, 4'h0};
		steps[14] = '{RD, 16'h02FF, 32'h0, 32'h0, 1'b0, 4'h0};
		// Unmapped blocks answer error
		steps[15] = '{WR, 16'h0300, 32'hFFFF_FFFF, 32'h0, 1'b1, 4'h0};
		steps[16] = '{RD, 16'h0000, 32'h0, 32'h0, 1'b1, 4'h0};
		steps[17] = '{WR, 16'hFF01, 32'h0, 32'h0, 1'b1, 4'h0};
		// Nothing moved behind the errors
		steps[18] = '{RD, 16'h0100, 32'h0, 32'h0000_0001, 1'b0, 4'h0};
		steps[19] = '{RD, 16'h0200, 32'h0, busData_t'(PWM_PERIOD), 1'b0, 4'h0};
		steps[20] = '{RD, 16'h0201, 32'h0, busData_t'(PWM_DUTY), 1'b0, 4'h0};
		steps[21] = '{WR, 16'h0202, 32'h0000_0003, 32'h0, 1'b0, 4'h0};
		steps[22] = '{RD, 16'h0202, 32'h0, 32'h0000_0001, 1'b0, 4'h0};
	endtask

	// Register map as specified, mapped blocks only
	task automatic updateModel(input logic write, input busAdrs_t adrs, input busData_t wData);
		if (write && adrs[15:8] == `GPIO_BLOCK_ID && adrs[7:0] == 8'h00)
			ledModel = wData[`LED_WIDTH-1:0];
		if (write && adrs[15:8] == `PWM_BLOCK_ID)
		begin
			case (adrs[7:0])
				8'h00: periodModel = wData[15:0];
				8'h01: dutyModel = wData[15:0];
				8'h02: enableModel = wData[0];
				default: ;
			endcase
		end
	endtask

	//----------------------------------------------------------
	// One host transaction, entered and left on a falling edge
	//----------------------------------------------------------
	task automatic runStep(input logic write, input busAdrs_t adrs, input busData_t wData,
		input busData_t expData, input logic expErr);
		int waited;
		int latency;
		int stall;
		cmdValid = 1'b1;
		cmdWrite = write;
		cmdAdrs = adrs;
		cmdData = wData;
		// Ready seen here means the next rising edge takes the command
		waited = 0;
		while (!cmdReady && waited < RSP_LIMIT)
		begin
			@(negedge sysClk);
			waited++;
		end
		assert (cmdReady) else failRun($sformatf("Command to %h was never accepted", adrs));
		@(negedge sysClk);
		cmdValid = 1'b0;
		// Falling edges counted from the accepting edge
		latency = 1;
		while (!rspValid && latency < RSP_LIMIT)
		begin
			@(negedge sysClk);
			latency++;
		end
		assert (rspValid) else failRun($sformatf("No response to the command at %h", adrs));
		checkValue("response latency", latency, RSP_LATENCY);
		checkValue("rspData", rspData, expData);
		checkValue("rspError", rspError, expErr);
		// Host stalls, response must hold
		stall = {$random(seed)} % (MAX_STALL + 1);
		repeat (stall)
		begin
			@(negedge sysClk);
			assert (rspValid) else failRun("rspValid dropped while rspReady was low");
			checkValue("rspData", rspData, expData);
			checkValue("rspError", rspError, expErr);
		end
		rspReady = 1'b1;
		@(negedge sysClk);
		rspReady = 1'b0;
		assert (!rspValid) else failRun("rspValid stayed high after the response was taken");
		checkValue("cmdReady", cmdReady, 1);
	endtask

	//----------------------------------------------------------
	// Backlight checks
	//----------------------------------------------------------
	task automatic checkDuty();
		int window;
		int highCount;
		window = DUTY_PERIODS * (int'(periodModel) + 1);
		highCount = 0;
		repeat (window)
		begin
			@(negedge sysClk);
			if (backlight)
				highCount++;
		end
		checkValue("backlight high cycles", highCount, DUTY_PERIODS * int'(dutyModel));
	endtask

	task automatic checkOff();
		repeat (OFF_PERIODS * (int'(periodModel) + 1))
		begin
			@(negedge sysClk);
			checkValue("backlight", backlight, 0);
		end
	endtask

	//----------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------
	initial
	begin
		seed = 32'hb053bee1;
		cmdValid = 1'b0;
		cmdWrite = 1'b0;
		cmdAdrs = '0;
		cmdData = '0;
		rspReady = 1'b0;
		gpioIn = '0;
		ledModel = '0;
		periodModel = '0;
		dutyModel = '0;
		enableModel = 1'b0;
		loadTable();
		@(negedge reset);
		@(negedge sysClk);
		// Reset state
		checkValue("cmdReady", cmdReady, 1);
		checkValue("rspValid", rspValid, 0);
		checkValue("leds", leds, 0);
		checkValue("backlight", backlight, 0);
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			// Pins settle through both sync flops before the access
			gpioIn = steps[i].pins;
			repeat (SETTLE_CYCLES) @(negedge sysClk);
			runStep(steps[i].write, steps[i].adrs, steps[i].wData, steps[i].rData, steps[i].err);
			updateModel(steps[i].write, steps[i].adrs, steps[i].wData);
			checkValue("leds", leds, ledModel);
		end
		checkDuty();
		// Switch the backlight off
		runStep(WR, 16'h0202, 32'h0, 32'h0, 1'b0);
		updateModel(WR, 16'h0202, 32'h0);
		checkOff();
		$display("Simulation finished: PASS");
		$finish;
	end

	// Time budget from the row count and the PWM windows
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		failRun("Watchdog expired before the test sequence completed");
	end

endmodule

`default_nettype wire

// File: verif/clockGen.sv
// Clock starts low at time 0; reset stays high over 4 rising edges and drops on a falling edge
`default_nettype none

module clockGen (
	output logic sysClk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 4;

	initial
	begin
		sysClk = 1'b0;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge sysClk);
		// Release away from the sampling edge
		@(negedge sysClk);
		reset = 1'b0;
	end

	always #(HALF_PERIOD) sysClk = !sysClk;

endmodule

`default_nettype wire

// File: rtl/processer.sv
// Host port feeds one bus master; only GPIO (01) and PWM (02) are mapped, other blocks answer error
`default_nettype none

`include "usiBus_settings.svh"

module processer (
	input logic sysClk,
	input logic reset,
	// Host command
	input logic cmdValid,
	output logic cmdReady,
	input logic cmdWrite,
	input usiPkg::busAdrs_t cmdAdrs,
	input usiPkg::busData_t cmdData,
	// Host response
	output logic rspValid,
	input logic rspReady,
	output usiPkg::busData_t rspData,
	output logic rspError,
	// Pins
	output logic [`LED_WIDTH-1:0] leds,
	input logic [`GPIO_IN_WIDTH-1:0] gpioIn,
	output logic backlight
);
	import usiPkg::*;

	//----------------------------------------------------------
	// Shared bus, master side
	//----------------------------------------------------------
	busAdrs_t busAdrs;
	busData_t busWd;
	logic busWCke;
	logic busRCke;
	busData_t busRd;
	logic busVd;
	logic busErr;

	// Per-slave strobes and answers
	logic gpioWCke;
	logic gpioRCke;
	busData_t gpioRd;
	logic gpioVd;
	logic pwmWCke;
	logic pwmRCke;
	busData_t pwmRd;
	logic pwmVd;

	usiBusMaster u_busMaster (.sysClk, .reset, .cmdValid, .cmdReady, .cmdWrite, .cmdAdrs,
		.cmdData, .rspValid, .rspReady, .rspData, .rspError, .busAdrs, .busWd, .busWCke,
		.busRCke, .busRd, .busVd, .busErr);

	usiInterconnect u_interconnect (.sysClk, .reset, .busAdrs, .busWCke, .busRCke, .busRd,
		.busVd, .busErr, .gpioWCke, .gpioRCke, .gpioRd, .gpioVd, .pwmWCke, .pwmRCke,
		.pwmRd, .pwmVd);

	//----------------------------------------------------------
	// Slaves
	//----------------------------------------------------------
	gpioBlock u_gpioBlock (.sysClk, .reset, .busAdrs, .busWd, .wCke(gpioWCke),
		.rCke(gpioRCke), .rd(gpioRd), .vd(gpioVd), .leds, .gpioIn);

	pwmBlock u_pwmBlock (.sysClk, .reset, .busAdrs, .busWd, .wCke(pwmWCke), .rCke(pwmRCke),
		.rd(pwmRd), .vd(pwmVd), .pwm(backlight));

endmodule

`default_nettype wire

// File: rtl/pwmBlock.sv
// Duty above period+1 just means always on; pwm is a registered output, low whenever enable is 0
`default_nettype none

module pwmBlock (
	input logic sysClk,
	input logic reset,
	// Bus side
	input usiPkg::busAdrs_t busAdrs,
	input usiPkg::busData_t busWd,
	input logic wCke,
	input logic rCke,
	output usiPkg::busData_t rd,
	output logic vd,
	// Backlight pin
	output logic pwm
);
	import usiPkg::*;

	localparam regOffset_t PERIOD_OFFSET = 8'h00;
	localparam regOffset_t DUTY_OFFSET = 8'h01;
	localparam regOffset_t ENABLE_OFFSET = 8'h02;

	regOffset_t offset;
	pwmCount_t period;
	pwmCount_t duty;
	logic enable;
	pwmCount_t count;
	// Values after this edge
	pwmCount_t dutyNext;
	logic enableNext;
	pwmCount_t countNext;

	assign offset = busAdrs[7:0];

	//----------------------------------------------------------
	// Next-state for the waveform
	//----------------------------------------------------------
	always_comb
	begin
		dutyNext = duty;
		enableNext = enable;
		if (wCke && (offset == DUTY_OFFSET))
			dutyNext = busWd[$bits(pwmCount_t)-1:0];
		if (wCke && (offset == ENABLE_OFFSET))
			enableNext = busWd[0];
		// Counter parks at 0 while off, wraps after period
		if (!enable || (count >= period))
			countNext = '0;
		else
			countNext = count + 1'b1;
	end

	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			period <= '0;
			duty <= '0;
			enable <= 1'b0;
			count <= '0;
			pwm <= 1'b0;
			vd <= 1'b0;
		end
		else
		begin
			if (wCke && (offset == PERIOD_OFFSET))
				period <= busWd[$bits(pwmCount_t)-1:0];
			duty <= dutyNext;
			enable <= enableNext;
			count <= countNext;
			// Output lines up with the registered enable and count
			pwm <= enableNext && (countNext < dutyNext);
			vd <= wCke || rCke;
		end
	end

	//----------------------------------------------------------
	// Read back
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		rd <= '0;
		if (rCke)
		begin
			case (offset)
				PERIOD_OFFSET: rd <= busData_t'(period);
				DUTY_OFFSET: rd <= busData_t'(duty);
				ENABLE_OFFSET: rd <= busData_t'(enable);
				default: rd <= '0;
			endcase
		end
	end

	// Clearing enable over the bus stops the output on the next cycle
	pwmOffCheck: assert property (@(posedge sysClk) disable iff (reset)
		wCke && (offset == ENABLE_OFFSET) && !busWd[0] |=> !enable && !pwm);

endmodule

`default_nettype wire

// File: rtl/gpioBlock.sv
// Offsets 0 and 1 only; gpioIn is async and read two cycles late through a plain two-flop sync
`default_nettype none

`include "usiBus_settings.svh"

module gpioBlock (
	input logic sysClk,
	input logic reset,
	// Bus side
	input usiPkg::busAdrs_t busAdrs,
	input usiPkg::busData_t busWd,
	input logic wCke,
	input logic rCke,
	output usiPkg::busData_t rd,
	output logic vd,
	// Pins
	output logic [`LED_WIDTH-1:0] leds,
	input logic [`GPIO_IN_WIDTH-1:0] gpioIn
);
	import usiPkg::*;

	localparam regOffset_t LED_OFFSET = 8'h00;
	localparam regOffset_t IN_OFFSET = 8'h01;

	regOffset_t offset;
	// Input synchronizer stages
	logic [`GPIO_IN_WIDTH-1:0] inMeta;
	logic [`GPIO_IN_WIDTH-1:0] inSync;

	assign offset = busAdrs[`USI_BLOCK_BITS-1:0];

	//----------------------------------------------------------
	// LED register and answer valid
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			leds <= '0;
			vd <= 1'b0;
		end
		else
		begin
			if (wCke && (offset == LED_OFFSET))
				leds <= busWd[`LED_WIDTH-1:0];
			// Every strobe gets an answer, mapped offset or not
			vd <= wCke || rCke;
		end
	end

	//----------------------------------------------------------
	// Input sync and read data
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		inMeta <= gpioIn;
		inSync <= inMeta;
		rd <= '0;
		if (rCke)
		begin
			case (offset)
				LED_OFFSET: rd <= busData_t'(leds);
				IN_OFFSET: rd <= busData_t'(inSync);
				default: rd <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/usiInterconnect.sv
// Decodes only the upper address byte; slaves see the full address and decode the offset
`default_nettype none

`include "usiBus_settings.svh"

module usiInterconnect (
	input logic sysClk,
	input logic reset,
	// From the master
	input usiPkg::busAdrs_t busAdrs,
	input logic busWCke,
	input logic busRCke,
	// Back to the master
	output usiPkg::busData_t busRd,
	output logic busVd,
	output logic busErr,
	// GPIO block
	output logic gpioWCke,
	output logic gpioRCke,
	input usiPkg::busData_t gpioRd,
	input logic gpioVd,
	// PWM block
	output logic pwmWCke,
	output logic pwmRCke,
	input usiPkg::busData_t pwmRd,
	input logic pwmVd
);
	import usiPkg::*;

	blockId_t blockSel;
	logic gpioHit;
	logic pwmHit;
	// Strobe that matches no block
	logic missStrobe;
	// Error answer for an unmapped block
	logic errVd;

	//----------------------------------------------------------
	// Block decode
	//----------------------------------------------------------
	assign blockSel = busAdrs[`USI_ADRS_BITS-1 -: `USI_BLOCK_BITS];
	assign gpioHit = (blockSel == `GPIO_BLOCK_ID);
	assign pwmHit = (blockSel == `PWM_BLOCK_ID);

	// Strobes steered straight through
	assign gpioWCke = busWCke && gpioHit;
	assign gpioRCke = busRCke && gpioHit;
	assign pwmWCke = busWCke && pwmHit;
	assign pwmRCke = busRCke && pwmHit;

	assign missStrobe = (busWCke || busRCke) && !gpioHit && !pwmHit;

	//----------------------------------------------------------
	// Unmapped block answer
	//----------------------------------------------------------
	// Same one-cycle latency as a real slave
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			errVd <= 1'b0;
		end
		else
		begin
			errVd <= missStrobe;
		end
	end

	//----------------------------------------------------------
	// Response mux
	//----------------------------------------------------------
	// Each slave's data only counts while its vd is up
	assign busRd = ({`USI_DATA_BITS{gpioVd}} & gpioRd) | ({`USI_DATA_BITS{pwmVd}} & pwmRd);
	assign busVd = gpioVd || pwmVd || errVd;
	assign busErr = errVd;

	// One answer per strobe across slaves and the error path
	singleAnswerCheck: assert property (@(posedge sysClk) disable iff (reset)
		$onehot0({gpioVd, pwmVd, errVd}));

endmodule

`default_nettype wire

// File: rtl/usiBusMaster.sv
// One command in flight; the host must hold command fields while cmdValid is high
`default_nettype none

module usiBusMaster (
	input logic sysClk,
	input logic reset,
	// Host command
	input logic cmdValid,
	output logic cmdReady,
	input logic cmdWrite,
	input usiPkg::busAdrs_t cmdAdrs,
	input usiPkg::busData_t cmdData,
	// Host response
	output logic rspValid,
	input logic rspReady,
	output usiPkg::busData_t rspData,
	output logic rspError,
	// Shared bus
	output usiPkg::busAdrs_t busAdrs,
	output usiPkg::busData_t busWd,
	output logic busWCke,
	output logic busRCke,
	input usiPkg::busData_t busRd,
	input logic busVd,
	input logic busErr
);
	import usiPkg::*;

	masterState_e state;
	// Handshake and bus completion events
	logic cmdAccept;
	logic rspAccept;
	logic busDone;

	// Commands are only taken while idle
	assign cmdReady = (state == IDLE);
	assign cmdAccept = cmdValid && cmdReady;
	assign rspAccept = rspValid && rspReady;
	assign busDone = (state == WAIT) && busVd;

	//----------------------------------------------------------
	// Control FSM and strobes
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			state <= IDLE;
			busWCke <= 1'b0;
			busRCke <= 1'b0;
			rspValid <= 1'b0;
		end
		else
		begin
			// Strobes last one cycle
			busWCke <= 1'b0;
			busRCke <= 1'b0;
			unique case (state)
				IDLE:
				begin
					if (cmdAccept)
					begin
						state <= ISSUE;
						busWCke <= cmdWrite;
						busRCke <= !cmdWrite;
					end
				end
				// Strobe is on the bus in this state
				ISSUE: state <= WAIT;
				WAIT:
				begin
					if (busVd)
					begin
						state <= RESPOND;
						rspValid <= 1'b1;
					end
				end
				RESPOND:
				begin
					if (rspAccept)
					begin
						state <= IDLE;
						rspValid <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	//----------------------------------------------------------
	// Command and response payload
	//----------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (cmdAccept)
		begin
			busAdrs <= cmdAdrs;
			busWd <= cmdData;
		end
		// Slave answer captured once, held through RESPOND
		if (busDone)
		begin
			rspData <= busRd;
			rspError <= busErr;
		end
	end

	// Response must not move while the host stalls
	rspHoldCheck: assert property (@(posedge sysClk) disable iff (reset)
		rspValid && !rspReady |=> rspValid && $stable(rspData));

	// One kind of access per strobe, answered on the next cycle
	strobeExclusiveCheck: assert property (@(posedge sysClk) disable iff (reset)
		(busWCke || busRCke) |=> busVd && !$past(busWCke && busRCke));

endmodule

`default_nettype wire

// File: rtl/usiPkg.sv
// Bus types for the peripheral subsystem; widths come from the settings header only
`default_nettype none

`include "usiBus_settings.svh"

package usiPkg;

	//----------------------------------------------------------
	// Bus words
	//----------------------------------------------------------
	// Full address, block byte on top of register byte
	typedef logic [`USI_ADRS_BITS-1:0] busAdrs_t;
	typedef logic [`USI_DATA_BITS-1:0] busData_t;

	// Upper address byte
	typedef logic [`USI_BLOCK_BITS-1:0] blockId_t;
	// Lower address byte
	typedef logic [`USI_BLOCK_BITS-1:0] regOffset_t;

	// Backlight counter, period and duty
	typedef logic [`PWM_COUNTER_BITS-1:0] pwmCount_t;

	//----------------------------------------------------------
	// Bus master FSM
	//----------------------------------------------------------
	typedef enum logic [1:0]
	{
		IDLE,
		ISSUE,
		WAIT,
		RESPOND
	} masterState_e;

endpackage

`default_nettype wire

// File: rtl/usiBus_settings.svh
// Bus widths and block codes; the block code must sit in the upper address byte
`ifndef USI_BUS_SETTINGS_SVH
`define USI_BUS_SETTINGS_SVH

//----------------------------------------------------------
// Bus geometry
//----------------------------------------------------------
`define USI_ADRS_BITS 16
`define USI_DATA_BITS 32
// Width of the block byte and of the register byte
`define USI_BLOCK_BITS 8

//----------------------------------------------------------
// Block address map, upper address byte
//----------------------------------------------------------
`define GPIO_BLOCK_ID 8'h01
`define PWM_BLOCK_ID 8'h02

// GPIO pin counts
`define LED_WIDTH 2
`define GPIO_IN_WIDTH 4
// Backlight counter, also period and duty width
`define PWM_COUNTER_BITS 16

`endif
